/* common/ipq_consts.svh */
`ifndef IPQ_CONSTS_SVH
`define IPQ_CONSTS_SVH

// virtual channels per input port
`define IPQ_V 4

// flit slots per vc
`define IPQ_B 4

// shortest packet, header plus tail
`define IPQ_MIN_PCK 2

// packets that can wait in one vc, ceil(B / MIN_PCK)
`define IPQ_MAX_PCK ((`IPQ_B + `IPQ_MIN_PCK - 1) / `IPQ_MIN_PCK)

`define IPQ_FPAY 32   // payload bits

// mesh router ports, local plus four directions
`define IPQ_P 5

// traffic classes
`define IPQ_C 2
`define IPQ_CW 1      // class field

// destination port number field in the header payload
`define IPQ_DSTW 3

`endif

/* common/ipq_pkg.sv */
`default_nettype none

`include "ipq_consts.svh"

package ipq_pkg;

    // one bit per virtual channel
    typedef logic [`IPQ_V-1:0] vc_mask_t;

    typedef logic [`IPQ_CW-1:0] class_t;

    // encoded port number, 0 to P-1
    typedef logic [`IPQ_DSTW-1:0] dst_port_t;

    // request over the other ports, own direction removed
    typedef logic [`IPQ_P-2:0] oport_mask_t;

    // header payload: dst port in the low bits, class right above
    typedef struct packed {
        logic                  hdr;
        logic                  tail;
        vc_mask_t              vc;
        logic [`IPQ_FPAY-1:0]  payload;
    } flit_t;

    typedef vc_mask_t [`IPQ_C-1:0] class_vc_tbl_t;

    // class 0 -> vc 0,1   class 1 -> vc 2,3
    localparam class_vc_tbl_t class_vc_table = {
        4'b1100,
        4'b0011
    };

endpackage

`default_nettype wire

/* hw/fwft_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// head item is always on dout_o, rd_i just drops it
module fwft_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  item_t din_i,
    input  logic  wr_i,
    input  logic  rd_i,
    output item_t dout_o,
    output logic  empty_o
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t          mem [DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           do_wr;
    logic           do_rd;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_rd = rd_i && (count != '0);       // pop of an empty fifo is ignored
    assign do_wr = wr_i && ((count != CW'(DEPTH)) || do_rd);

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= din_i;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    assign dout_o  = mem[rd_ptr];
    assign empty_o = (count == '0);

endmodule

`default_nettype wire

/* input_queue/header_extract.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipq_consts.svh"

// pure decode of the incoming flit, no state
module header_extract (
    input  ipq_pkg::flit_t     flit_i,
    input  logic               flit_we_i,
    output ipq_pkg::vc_mask_t  flit_wr_o,
    output ipq_pkg::vc_mask_t  hdr_wr_o,
    output logic               tail_flg_o,
    output ipq_pkg::class_t    class_o,
    output ipq_pkg::dst_port_t dst_port_o
);
    import ipq_pkg::*;

    vc_mask_t vc_sel;

    assign vc_sel = flit_i.vc;   // one-hot from upstream

    // every flit goes to the buffer, only headers feed the route queues
    assign flit_wr_o = flit_we_i ? vc_sel : '0;
    assign hdr_wr_o  = (flit_we_i && flit_i.hdr) ? vc_sel : '0;

    assign tail_flg_o = flit_i.tail;

    // fields are only meaningful while hdr is set
    assign dst_port_o = flit_i.payload[`IPQ_DSTW-1:0];
    assign class_o    = flit_i.payload[`IPQ_DSTW +: `IPQ_CW];

endmodule

`default_nettype wire

/* input_queue/vc_flit_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipq_consts.svh"

module vc_flit_buffer (
    input  logic              clk,
    input  logic              reset,
    input  ipq_pkg::flit_t    flit_i,
    input  ipq_pkg::vc_mask_t flit_wr_i,
    input  ipq_pkg::vc_mask_t rd_vc_i,
    output ipq_pkg::flit_t    flit_o,
    output ipq_pkg::vc_mask_t not_empty_o
);
    import ipq_pkg::*;

    localparam int PW = (`IPQ_B > 1) ? $clog2(`IPQ_B) : 1;
    localparam int CW = $clog2(`IPQ_B + 1);
    localparam int VW = (`IPQ_V > 1) ? $clog2(`IPQ_V) : 1;

    flit_t          mem    [`IPQ_V][`IPQ_B];
    logic [PW-1:0]  wr_ptr [`IPQ_V];
    logic [PW-1:0]  rd_ptr [`IPQ_V];
    logic [CW-1:0]  count  [`IPQ_V];
    logic [VW-1:0]  rd_idx;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(`IPQ_B - 1)) ? '0 : p + 1'b1;
    endfunction

    // shared write port, flit_wr_i picks the vc
    always_ff @(posedge clk) begin
        for (int v = 0; v < `IPQ_V; v++) begin
            if (flit_wr_i[v]) mem[v][wr_ptr[v]] <= flit_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < `IPQ_V; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v]  <= '0;
            end
        end else begin
            for (int v = 0; v < `IPQ_V; v++) begin
                if (flit_wr_i[v]) wr_ptr[v] <= ptr_inc(wr_ptr[v]);
                if (rd_vc_i[v])   rd_ptr[v] <= ptr_inc(rd_ptr[v]);  // grant = pop
                case ({flit_wr_i[v], rd_vc_i[v]})
                    2'b10:   count[v] <= count[v] + 1'b1;
                    2'b01:   count[v] <= count[v] - 1'b1;
                    default: count[v] <= count[v];
                endcase
            end
        end
    end

    // one-hot grant to index
    always_comb begin
        rd_idx = '0;
        for (int v = 0; v < `IPQ_V; v++) begin
            if (rd_vc_i[v]) rd_idx = VW'(v);
        end
    end

    assign flit_o = mem[rd_idx][rd_ptr[rd_idx]];

    always_comb begin
        for (int v = 0; v < `IPQ_V; v++) begin
            not_empty_o[v] = (count[v] != '0);
        end
    end

endmodule

`default_nettype wire

/* input_queue/ivc_route_info.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipq_consts.svh"

module ivc_route_info #(
    parameter int SW_LOC = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ipq_pkg::vc_mask_t    flit_wr_i,
    input  ipq_pkg::vc_mask_t    hdr_wr_i,
    input  logic                 tail_flg_i,
    input  ipq_pkg::class_t      class_i,
    input  ipq_pkg::dst_port_t   dst_port_i,
    input  ipq_pkg::vc_mask_t    rd_vc_i,
    input  ipq_pkg::vc_mask_t    release_vc_i,
    output ipq_pkg::vc_mask_t    flit_is_tail_o,
    output ipq_pkg::oport_mask_t dest_port_o      [`IPQ_V],
    output ipq_pkg::vc_mask_t    candidate_ovcs_o [`IPQ_V]
);
    import ipq_pkg::*;

    vc_mask_t  tail_head;
    vc_mask_t  tail_empty;
    vc_mask_t  cls_empty;
    vc_mask_t  dst_empty;
    class_t    cls_head [`IPQ_V];
    dst_port_t dst_head [`IPQ_V];

    // bit i of the request is port i below SW_LOC and port i+1 above it
    function automatic oport_mask_t decode_dst(input dst_port_t p);
        oport_mask_t m;
        int          port_num;
        for (int i = 0; i < `IPQ_P - 1; i++) begin
            port_num = (i < SW_LOC) ? i : i + 1;
            m[i] = (int'(p) == port_num);
        end
        return m;
    endfunction

    for (genvar v = 0; v < `IPQ_V; v++) begin : g_vc
        // one entry per flit, popped on every grant
        fwft_fifo #(
            .item_t (logic),
            .DEPTH  (`IPQ_B)
        ) u_tail_fifo (
            .clk     (clk),
            .reset   (reset),
            .din_i   (tail_flg_i),
            .wr_i    (flit_wr_i[v]),
            .rd_i    (rd_vc_i[v]),
            .dout_o  (tail_head[v]),
            .empty_o (tail_empty[v])
        );

        // one entry per packet, popped when the vc is released
        fwft_fifo #(
            .item_t (class_t),
            .DEPTH  (`IPQ_MAX_PCK)
        ) u_class_fifo (
            .clk     (clk),
            .reset   (reset),
            .din_i   (class_i),
            .wr_i    (hdr_wr_i[v]),
            .rd_i    (release_vc_i[v]),
            .dout_o  (cls_head[v]),
            .empty_o (cls_empty[v])
        );

        fwft_fifo #(
            .item_t (dst_port_t),
            .DEPTH  (`IPQ_MAX_PCK)
        ) u_dst_fifo (
            .clk     (clk),
            .reset   (reset),
            .din_i   (dst_port_i),
            .wr_i    (hdr_wr_i[v]),
            .rd_i    (release_vc_i[v]),
            .dout_o  (dst_head[v]),
            .empty_o (dst_empty[v])
        );

        // nothing requested while no packet is queued
        assign dest_port_o[v]      = dst_empty[v] ? '0 : decode_dst(dst_head[v]);
        assign candidate_ovcs_o[v] = cls_empty[v] ? '0 : class_vc_table[cls_head[v]];
    end

    assign flit_is_tail_o = tail_head & ~tail_empty;

endmodule

`default_nettype wire

/* input_queue/flit_out_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipq_consts.svh"

module flit_out_stage (
    input  logic              clk,
    input  logic              reset,
    input  ipq_pkg::vc_mask_t grant_i,
    input  ipq_pkg::flit_t    flit_i,
    input  ipq_pkg::vc_mask_t assigned_ovc_i [`IPQ_V],
    output ipq_pkg::flit_t    flit_o,
    output logic              flit_we_o
);
    import ipq_pkg::*;

    vc_mask_t ovc_sel;
    flit_t    flit_mod;

    // output vc of the granted input vc
    always_comb begin
        ovc_sel = '0;
        for (int v = 0; v < `IPQ_V; v++) begin
            if (grant_i[v]) ovc_sel = assigned_ovc_i[v];
        end
        flit_mod    = flit_i;
        flit_mod.vc = ovc_sel;   // flags and payload pass unchanged
    end

    always_ff @(posedge clk) begin
        if (|grant_i) flit_o <= flit_mod;
    end

    // one strobe per grant, a cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_we_o <= 1'b0;
        end else begin
            flit_we_o <= |grant_i;
        end
    end

endmodule

`default_nettype wire

/* input_queue/input_queue_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipq_consts.svh"

// one mesh router input port, SW_LOC is its own direction
module input_queue_port #(
    parameter int SW_LOC = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ipq_pkg::flit_t       flit_in_i,
    input  logic                 flit_in_we_i,
    input  ipq_pkg::vc_mask_t    ivc_grant_i,
    input  ipq_pkg::vc_mask_t    reset_ivc_i,
    input  ipq_pkg::vc_mask_t    assigned_ovc_i   [`IPQ_V],
    output ipq_pkg::vc_mask_t    ivc_request_o,
    output ipq_pkg::vc_mask_t    flit_is_tail_o,
    output ipq_pkg::oport_mask_t dest_port_o      [`IPQ_V],
    output ipq_pkg::vc_mask_t    candidate_ovcs_o [`IPQ_V],
    output ipq_pkg::flit_t       flit_out_o,
    output logic                 flit_out_we_o
);
    import ipq_pkg::*;

    vc_mask_t  flit_wr;
    vc_mask_t  hdr_wr;
    logic      tail_flg;
    class_t    class_in;
    dst_port_t dst_port_in;
    flit_t     head_flit;

    header_extract u_header_extract (
        .flit_i     (flit_in_i),
        .flit_we_i  (flit_in_we_i),
        .flit_wr_o  (flit_wr),
        .hdr_wr_o   (hdr_wr),
        .tail_flg_o (tail_flg),
        .class_o    (class_in),
        .dst_port_o (dst_port_in)
    );

    // a vc requests while it holds any flit
    vc_flit_buffer u_flit_buffer (
        .clk         (clk),
        .reset       (reset),
        .flit_i      (flit_in_i),
        .flit_wr_i   (flit_wr),
        .rd_vc_i     (ivc_grant_i),
        .flit_o      (head_flit),
        .not_empty_o (ivc_request_o)
    );

    ivc_route_info #(
        .SW_LOC (SW_LOC)
    ) u_route_info (
        .clk              (clk),
        .reset            (reset),
        .flit_wr_i        (flit_wr),
        .hdr_wr_i         (hdr_wr),
        .tail_flg_i       (tail_flg),
        .class_i          (class_in),
        .dst_port_i       (dst_port_in),
        .rd_vc_i          (ivc_grant_i),
        .release_vc_i     (reset_ivc_i),
        .flit_is_tail_o   (flit_is_tail_o),
        .dest_port_o      (dest_port_o),
        .candidate_ovcs_o (candidate_ovcs_o)
    );

    flit_out_stage u_flit_out (
        .clk            (clk),
        .reset          (reset),
        .grant_i        (ivc_grant_i),
        .flit_i         (head_flit),
        .assigned_ovc_i (assigned_ovc_i),
        .flit_o         (flit_out_o),
        .flit_we_o      (flit_out_we_o)
    );

endmodule

`default_nettype wire

/* bench/iq_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipq_consts.svh"

// protocol properties of the input port, bound to the top level
module iq_chk (
    input logic              clk,
    input logic              reset,
    input ipq_pkg::vc_mask_t grant_i,
    input ipq_pkg::vc_mask_t request_i,
    input ipq_pkg::vc_mask_t flit_wr_i,
    input logic              out_we_i
);
    import ipq_pkg::*;

    int       occ [`IPQ_V];     // flits held per vc
    vc_mask_t full;
    int       grant_fails = 0;
    int       we_fails    = 0;
    int       full_fails  = 0;
    int       fail_count;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < `IPQ_V; v++) begin
                occ[v] <= 0;
            end
        end else begin
            for (int v = 0; v < `IPQ_V; v++) begin
                occ[v] <= occ[v] + int'(flit_wr_i[v]) - int'(grant_i[v]);
            end
        end
    end

    always_comb begin
        for (int v = 0; v < `IPQ_V; v++) begin
            full[v] = (occ[v] >= `IPQ_B);
        end
    end

    assign fail_count = grant_fails + we_fails + full_fails;

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        (grant_i != '0) |-> ($onehot(grant_i) && ((grant_i & request_i) != '0)))
        else begin
            $error("grant is not one-hot or names a vc without a request");
            grant_fails++;
        end

    // output strobe exactly one cycle after each grant, and never otherwise
    a_we_after_grant: assert property (@(posedge clk) disable iff (reset)
        (grant_i != '0) |=> out_we_i)
        else begin
            $error("no output strobe one cycle after a grant");
            we_fails++;
        end

    a_no_we_without_grant: assert property (@(posedge clk) disable iff (reset)
        (grant_i == '0) |=> !out_we_i)
        else begin
            $error("output strobe without a grant in the cycle before");
            we_fails++;
        end

    a_no_full_write: assert property (@(posedge clk) disable iff (reset)
        (flit_wr_i & full) == '0)
        else begin
            $error("flit written to a full vc");
            full_fails++;
        end

endmodule

bind input_queue_port iq_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .grant_i   (ivc_grant_i),
    .request_i (ivc_request_o),
    .flit_wr_i (flit_wr),
    .out_we_i  (flit_out_we_o)
);

`default_nettype wire

/* bench/iq_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipq_consts.svh"

// reference queues per vc, compared with the port outputs on every edge
module iq_monitor (
    input logic                 clk,
    input logic                 reset,
    input ipq_pkg::flit_t       flit_in_i,
    input logic                 flit_in_we_i,
    input ipq_pkg::oport_mask_t exp_dest_i,       // expected route of the header
    input ipq_pkg::vc_mask_t    exp_cand_i,
    input ipq_pkg::vc_mask_t    grant_i,
    input ipq_pkg::vc_mask_t    release_i,
    input ipq_pkg::vc_mask_t    assigned_ovc_i [`IPQ_V],
    input ipq_pkg::vc_mask_t    request_i,
    input ipq_pkg::vc_mask_t    tail_i,
    input ipq_pkg::oport_mask_t dest_port_i    [`IPQ_V],
    input ipq_pkg::vc_mask_t    cand_ovcs_i    [`IPQ_V],
    input ipq_pkg::flit_t       flit_out_i,
    input logic                 flit_out_we_i
);
    import ipq_pkg::*;

    string       test_name = "reset";
    int          err_count = 0;
    flit_t       flit_q [`IPQ_V][$];
    oport_mask_t dest_q [`IPQ_V][$];   // one entry per queued packet
    vc_mask_t    cand_q [`IPQ_V][$];
    flit_t       pend_flit;
    logic        pend_valid = 1'b0;

    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            err_count++;
            $display("** Error [%s] %s at %0t: expected %h, actual %h",
                     test_name, what, $time, exp, act);
        end
    endtask

    function automatic int vc_index(input vc_mask_t m);
        int idx;
        idx = 0;
        for (int v = 0; v < `IPQ_V; v++) begin
            if (m[v]) idx = v;
        end
        return idx;
    endfunction

    task automatic check_outputs();
        logic [63:0] exp_tail;
        logic [63:0] exp_dest;
        logic [63:0] exp_cand;
        for (int v = 0; v < `IPQ_V; v++) begin
            exp_tail = '0;
            exp_dest = '0;
            exp_cand = '0;
            if (flit_q[v].size() != 0) exp_tail = 64'(flit_q[v][0].tail);
            if (dest_q[v].size() != 0) begin
                exp_dest = 64'(dest_q[v][0]);
                exp_cand = 64'(cand_q[v][0]);
            end
            compare($sformatf("vc%0d request", v), 64'(flit_q[v].size() != 0),
                    64'(request_i[v]));
            compare($sformatf("vc%0d tail flag", v), exp_tail, 64'(tail_i[v]));
            compare($sformatf("vc%0d dest port", v), exp_dest, 64'(dest_port_i[v]));
            compare($sformatf("vc%0d candidate vcs", v), exp_cand, 64'(cand_ovcs_i[v]));
        end
        compare("flit_out_we", 64'(pend_valid), 64'(flit_out_we_i));
        if (pend_valid && flit_out_we_i) compare("flit_out", 64'(pend_flit), 64'(flit_out_i));
    endtask

    task automatic apply_inputs();
        int    g;
        int    w;
        flit_t f;
        pend_valid = |grant_i;
        if (|grant_i) begin
            g = vc_index(grant_i);
            if (flit_q[g].size() == 0) begin
                err_count++;
                $display("%s: vc%0d was granted with no flit stored", test_name, g);
                pend_valid = 1'b0;
            end else begin
                f = flit_q[g].pop_front();
                f.vc = assigned_ovc_i[g];   // only the vc field changes
                pend_flit = f;
            end
        end
        if (flit_in_we_i) begin
            w = vc_index(flit_in_i.vc);
            flit_q[w].push_back(flit_in_i);
            if (flit_in_i.hdr) begin
                dest_q[w].push_back(exp_dest_i);
                cand_q[w].push_back(exp_cand_i);
            end
        end
        for (int v = 0; v < `IPQ_V; v++) begin
            if (release_i[v] && dest_q[v].size() != 0) begin
                void'(dest_q[v].pop_front());
                void'(cand_q[v].pop_front());
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pend_valid = 1'b0;
            for (int v = 0; v < `IPQ_V; v++) begin
                flit_q[v].delete();
                dest_q[v].delete();
                cand_q[v].delete();
            end
        end else begin
            check_outputs();    // pre-edge state first
            apply_inputs();
        end
    end

endmodule

`default_nettype wire

/* bench/tb_input_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipq_consts.svh"

module tb_input_queue;
    import ipq_pkg::*;

    localparam int SW_LOC  = 2;     // expected dest masks assume this port
    localparam int NPKT    = 6;
    localparam int TIMEOUT = 20;    // cycles per wait

    typedef struct {
        int          vc;
        int          cls;
        int          dst;
        int          len;
        int          rd;            // position in the drain order
        oport_mask_t exp_dest;
        vc_mask_t    exp_cand;
    } pkt_t;

    // vc, class, dst port, length, drain order, expected dest mask, expected candidates
    pkt_t tbl [NPKT] = '{
        '{0, 0, 1, 2, 0, 4'b0010, 4'b0011},
        '{1, 1, 0, 4, 2, 4'b0001, 4'b1100},
        '{2, 1, 3, 2, 1, 4'b0100, 4'b1100},
        '{3, 0, 4, 3, 4, 4'b1000, 4'b0011},
        '{0, 1, 4, 2, 3, 4'b1000, 4'b1100},   // second packet behind vc0
        '{2, 0, 0, 2, 5, 4'b0001, 4'b0011}
    };

    logic        clk = 1'b0;
    logic        reset;
    flit_t       flit_in;
    logic        flit_in_we;
    vc_mask_t    ivc_grant;
    vc_mask_t    reset_ivc;
    vc_mask_t    assigned_ovc   [`IPQ_V];
    vc_mask_t    ivc_request;
    vc_mask_t    flit_is_tail;
    oport_mask_t dest_port      [`IPQ_V];
    vc_mask_t    candidate_ovcs [`IPQ_V];
    flit_t       flit_out;
    logic        flit_out_we;
    oport_mask_t exp_dest;
    vc_mask_t    exp_cand;
    integer      seed = 32'hc80af769;
    int          timeout_errs = 0;

    initial begin
        forever #5 clk = ~clk;
    end

    input_queue_port #(.SW_LOC(SW_LOC)) i_dut (
        .clk              (clk),
        .reset            (reset),
        .flit_in_i        (flit_in),
        .flit_in_we_i     (flit_in_we),
        .ivc_grant_i      (ivc_grant),
        .reset_ivc_i      (reset_ivc),
        .assigned_ovc_i   (assigned_ovc),
        .ivc_request_o    (ivc_request),
        .flit_is_tail_o   (flit_is_tail),
        .dest_port_o      (dest_port),
        .candidate_ovcs_o (candidate_ovcs),
        .flit_out_o       (flit_out),
        .flit_out_we_o    (flit_out_we)
    );

    iq_monitor u_mon (
        .clk            (clk),
        .reset          (reset),
        .flit_in_i      (flit_in),
        .flit_in_we_i   (flit_in_we),
        .exp_dest_i     (exp_dest),
        .exp_cand_i     (exp_cand),
        .grant_i        (ivc_grant),
        .release_i      (reset_ivc),
        .assigned_ovc_i (assigned_ovc),
        .request_i      (ivc_request),
        .tail_i         (flit_is_tail),
        .dest_port_i    (dest_port),
        .cand_ovcs_i    (candidate_ovcs),
        .flit_out_i     (flit_out),
        .flit_out_we_i  (flit_out_we)
    );

    // r-th flit of the stream that vc v receives in table order
    function automatic bit locate_flit(input int v, input int r, output int e, output int k);
        int acc;
        acc = 0;
        e = 0;
        k = 0;
        for (int i = 0; i < NPKT; i++) begin
            if (tbl[i].vc == v) begin
                if (r < acc + tbl[i].len) begin
                    e = i;
                    k = r - acc;
                    return 1'b1;
                end
                acc += tbl[i].len;
            end
        end
        return 1'b0;
    endfunction

    task automatic send_flit(input int e, input int k);
        flit_t f;
        f.hdr     = (k == 0);
        f.tail    = (k == tbl[e].len - 1);
        f.vc      = vc_mask_t'(1 << tbl[e].vc);
        f.payload = $random(seed);
        if (f.hdr) begin
            f.payload[`IPQ_DSTW-1:0]        = dst_port_t'(tbl[e].dst);
            f.payload[`IPQ_DSTW +: `IPQ_CW] = class_t'(tbl[e].cls);
        end
        flit_in    = f;
        flit_in_we = 1'b1;
        exp_dest   = tbl[e].exp_dest;
        exp_cand   = tbl[e].exp_cand;
        @(negedge clk);
    endtask

    task automatic wait_request(input int v, output bit ok);
        int n;
        n = 0;
        while (!ivc_request[v] && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = ivc_request[v];
        if (!ok) begin
            timeout_errs++;
            $display("timeout: vc%0d never raised its request", v);
        end
    endtask

    task automatic wait_output(output bit ok);
        int n;
        n = 0;
        while (!flit_out_we && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = flit_out_we;
        if (!ok) begin
            timeout_errs++;
            $display("timeout: no output flit after a grant");
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (ivc_request != '0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ivc_request != '0) begin
            timeout_errs++;
            $display("timeout: requests still pending after all packets were drained");
        end
    endtask

    task automatic drain_packet(input int e);
        int v;
        bit ok;
        v = tbl[e].vc;
        u_mon.test_name = $sformatf("drain pkt%0d vc%0d", e, v);
        // one of the two output vcs that the class may use
        assigned_ovc[v] = vc_mask_t'(1 << (2 * tbl[e].cls + ($random(seed) & 1)));
        for (int k = 0; k < tbl[e].len; k++) begin
            wait_request(v, ok);
            if (!ok) return;
            ivc_grant = vc_mask_t'(1 << v);
            @(negedge clk);
            ivc_grant = '0;
            wait_output(ok);
            if (!ok) return;
        end
        reset_ivc = vc_mask_t'(1 << v);   // release the vc once its tail has left
        @(negedge clk);
        reset_ivc = '0;
    endtask

    initial begin
        int e;
        int k;
        int errs;
        reset      = 1'b1;
        flit_in    = '0;
        flit_in_we = 1'b0;
        ivc_grant  = '0;
        reset_ivc  = '0;
        exp_dest   = '0;
        exp_cand   = '0;
        for (int v = 0; v < `IPQ_V; v++) begin
            assigned_ovc[v] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        u_mon.test_name = "idle after reset";
        reset = 1'b0;
        @(negedge clk);

        u_mon.test_name = "interleaved write";
        for (int r = 0; r < `IPQ_B; r++) begin
            for (int v = 0; v < `IPQ_V; v++) begin
                if (locate_flit(v, r, e, k)) send_flit(e, k);
            end
        end
        flit_in_we = 1'b0;

        for (int r = 0; r < NPKT; r++) begin
            for (int i = 0; i < NPKT; i++) begin
                if (tbl[i].rd == r) drain_packet(i);
            end
        end

        u_mon.test_name = "final idle";
        wait_idle();
        repeat (2) @(negedge clk);

        errs = u_mon.err_count + timeout_errs + i_dut.u_chk.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 u_mon.err_count, timeout_errs, i_dut.u_chk.fail_count);
        if (errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/ipq_pkg.sv
hw/fwft_fifo.sv
input_queue/header_extract.sv
input_queue/vc_flit_buffer.sv
input_queue/ivc_route_info.sv
input_queue/flit_out_stage.sv
input_queue/input_queue_port.sv
bench/iq_chk.sv
bench/iq_monitor.sv
bench/tb_input_queue.sv

/* Makefile */
TOP = tb_input_queue

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
